// File: muldiv_pkg.sv
package muldiv_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    localparam int XLEN      = 32;           // operand and result width
    localparam int NUM_LANES = 4;            // arithmetic lanes behind the dispatcher
    localparam int LANE_W    = 2;            // lane pointer width
    localparam int DIV_STEPS = 32;           // one quotient bit per step

    ////////////////////////////////////////
    // operation codes
    ////////////////////////////////////////

    // multiplies sit in the lower half of the encoding
    typedef enum logic [2:0] {
        MUL    = 3'd0,                       // low word of a * b
        MULH   = 3'd1,                       // high word, signed x signed
        MULHSU = 3'd2,                       // high word, signed x unsigned
        MULHU  = 3'd3,                       // high word, unsigned x unsigned
        DIV    = 3'd4,                       // signed quotient
        DIVU   = 3'd5,                       // unsigned quotient
        REM    = 3'd6,                       // signed remainder
        REMU   = 3'd7                        // unsigned remainder
    } muldiv_op_e;

    ////////////////////////////////////////
    // lane FSM
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        L_IDLE = 3'd0,                       // ready for a request
        L_MUL  = 3'd1,                       // product being registered
        L_DIV  = 3'd2,                       // restoring steps
        L_FIX  = 3'd3,                       // sign correction
        L_DONE = 3'd4                        // result held until taken
    } lane_state_e;

endpackage

// File: muldiv_lane_if.sv
`timescale 1ns/1ps

interface muldiv_lane_if;

    // request side, dispatcher to lane
    logic                         req_valid;
    logic                         req_ready;
    muldiv_pkg::muldiv_op_e       op;
    logic [muldiv_pkg::XLEN-1:0]  opa;
    logic [muldiv_pkg::XLEN-1:0]  opb;

    // response side, lane to collector
    logic                         rsp_valid;
    logic                         rsp_ready;
    logic [muldiv_pkg::XLEN-1:0]  rsp_data;

    modport dispatch (
        output req_valid, op, opa, opb,
        input  req_ready
    );

    modport lane (
        input  req_valid, op, opa, opb,
        output req_ready,
        output rsp_valid, rsp_data,
        input  rsp_ready
    );

    modport collect (
        input  rsp_valid, rsp_data,
        output rsp_ready
    );

endinterface

// File: muldiv_dispatch.sv
`timescale 1ns/1ps

module muldiv_dispatch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  muldiv_pkg::muldiv_op_e       req_op_i,
    input  logic [muldiv_pkg::XLEN-1:0]  req_opa_i,
    input  logic [muldiv_pkg::XLEN-1:0]  req_opb_i,
    muldiv_lane_if.dispatch              lanes [muldiv_pkg::NUM_LANES]
);

    logic [muldiv_pkg::LANE_W-1:0]    issue_ptr;
    logic [muldiv_pkg::NUM_LANES-1:0] lane_ready;
    logic                             accept;

    ////////////////////////////////////////
    // request routing
    ////////////////////////////////////////

    for (genvar g = 0; g < muldiv_pkg::NUM_LANES; g++) begin : g_route
        // only the lane under the pointer sees valid
        assign lanes[g].req_valid = req_valid_i && (int'(issue_ptr) == g);
        assign lanes[g].op        = req_op_i;      // payload is broadcast
        assign lanes[g].opa       = req_opa_i;
        assign lanes[g].opb       = req_opb_i;
        assign lane_ready[g]      = lanes[g].req_ready;
    end

    assign req_ready_o = lane_ready[issue_ptr];    // stall while that lane is busy
    assign accept      = req_valid_i && req_ready_o;

    ////////////////////////////////////////
    // issue pointer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (int'(issue_ptr) == muldiv_pkg::NUM_LANES - 1) begin
                issue_ptr <= '0;                   // wrap to first lane
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

    // the collector relies on this order, so a stray move would reorder results
    a_issue_ptr_moves_on_accept : assert property (
        @(posedge clk) disable iff (reset)
        !accept |=> $stable(issue_ptr)
    ) else $error("issue pointer moved without an accepted request");

endmodule

// File: muldiv_lane.sv
`timescale 1ns/1ps

module muldiv_lane (
    input  logic           clk,
    input  logic           reset,
    muldiv_lane_if.lane    lane
);

    muldiv_pkg::lane_state_e          state_q;
    muldiv_pkg::muldiv_op_e           op_q;
    logic                             a_neg_q;       // dividend or multiplicand negative
    logic                             b_neg_q;
    logic [muldiv_pkg::XLEN-1:0]      opa_q;         // magnitude, shifts into the quotient
    logic [muldiv_pkg::XLEN-1:0]      opb_q;         // magnitude, also the divisor
    logic [muldiv_pkg::XLEN-1:0]      acc_q;         // partial remainder
    logic [$clog2(muldiv_pkg::DIV_STEPS)-1:0] step_q;
    logic [2*muldiv_pkg::XLEN-1:0]    prod_q;
    logic [muldiv_pkg::XLEN-1:0]      res_q;         // divide result

    logic                             accept;
    logic                             req_is_mul;
    logic                             a_neg;
    logic                             b_neg;
    logic                             div_zero;
    logic                             div_ovf;
    logic                             last_step;
    logic [muldiv_pkg::XLEN:0]        trial;
    logic [muldiv_pkg::XLEN:0]        diff;
    logic [muldiv_pkg::XLEN-1:0]      acc_next;
    logic [muldiv_pkg::XLEN-1:0]      quo_next;
    logic [2*muldiv_pkg::XLEN-1:0]    prod_mag;

    ////////////////////////////////////////
    // request decode
    ////////////////////////////////////////

    assign accept     = lane.req_valid && lane.req_ready;
    assign req_is_mul = lane.op inside {muldiv_pkg::MUL, muldiv_pkg::MULH,
                                        muldiv_pkg::MULHSU, muldiv_pkg::MULHU};

    // which operand is read as two's complement
    assign a_neg = lane.opa[muldiv_pkg::XLEN-1]
                && (lane.op inside {muldiv_pkg::MULH, muldiv_pkg::MULHSU,
                                    muldiv_pkg::DIV, muldiv_pkg::REM});
    assign b_neg = lane.opb[muldiv_pkg::XLEN-1]
                && (lane.op inside {muldiv_pkg::MULH, muldiv_pkg::DIV, muldiv_pkg::REM});

    assign div_zero = !req_is_mul && (lane.opb == '0);
    assign div_ovf  = (lane.op inside {muldiv_pkg::DIV, muldiv_pkg::REM})
                   && (lane.opa == {1'b1, {(muldiv_pkg::XLEN-1){1'b0}}})
                   && (lane.opb == '1);   // min / -1

    ////////////////////////////////////////
    // arithmetic
    ////////////////////////////////////////

    // unsigned product of magnitudes, sign applied afterwards
    assign prod_mag = (2*muldiv_pkg::XLEN)'(opa_q) * (2*muldiv_pkg::XLEN)'(opb_q);

    // one restoring step, dividend msb shifts into the remainder
    assign trial = {acc_q, opa_q[muldiv_pkg::XLEN-1]};
    assign diff  = trial - {1'b0, opb_q};

    always_comb begin
        if (!diff[muldiv_pkg::XLEN]) begin                 // no borrow, subtract fits
            acc_next = diff[muldiv_pkg::XLEN-1:0];
            quo_next = {opa_q[muldiv_pkg::XLEN-2:0], 1'b1};
        end else begin
            acc_next = trial[muldiv_pkg::XLEN-1:0];        // restore
            quo_next = {opa_q[muldiv_pkg::XLEN-2:0], 1'b0};
        end
    end

    assign last_step = int'(step_q) == muldiv_pkg::DIV_STEPS - 1;

    ////////////////////////////////////////
    // lane FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= muldiv_pkg::L_IDLE;
        end else begin
            case (state_q)
                muldiv_pkg::L_IDLE: begin
                    if (accept) begin
                        if (req_is_mul) begin
                            state_q <= muldiv_pkg::L_MUL;
                        end else if (div_zero || div_ovf) begin
                            state_q <= muldiv_pkg::L_DONE;    // fixed result, no steps
                        end else begin
                            state_q <= muldiv_pkg::L_DIV;
                        end
                    end
                end
                muldiv_pkg::L_MUL: state_q <= muldiv_pkg::L_DONE;
                muldiv_pkg::L_DIV: begin
                    if (last_step) begin
                        state_q <= muldiv_pkg::L_FIX;
                    end
                end
                muldiv_pkg::L_FIX: state_q <= muldiv_pkg::L_DONE;
                muldiv_pkg::L_DONE: begin
                    if (lane.rsp_ready) begin
                        state_q <= muldiv_pkg::L_IDLE;
                    end
                end
                default: state_q <= muldiv_pkg::L_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // datapath registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state_q)
            muldiv_pkg::L_IDLE: begin
                if (accept) begin
                    op_q    <= lane.op;
                    a_neg_q <= a_neg;
                    b_neg_q <= b_neg;
                    opa_q   <= a_neg ? -lane.opa : lane.opa;
                    opb_q   <= b_neg ? -lane.opb : lane.opb;
                    acc_q   <= '0;
                    step_q  <= '0;
                    if (div_zero) begin
                        // quotient all ones, remainder is the dividend
                        res_q <= (lane.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU})
                               ? '1 : lane.opa;
                    end else if (div_ovf) begin
                        res_q <= (lane.op == muldiv_pkg::DIV) ? lane.opa : '0;
                    end
                end
            end
            muldiv_pkg::L_MUL: begin
                prod_q <= (a_neg_q ^ b_neg_q) ? -prod_mag : prod_mag;
            end
            muldiv_pkg::L_DIV: begin
                acc_q  <= acc_next;
                opa_q  <= quo_next;
                step_q <= step_q + 1'b1;
            end
            muldiv_pkg::L_FIX: begin
                if (op_q inside {muldiv_pkg::DIV, muldiv_pkg::DIVU}) begin
                    res_q <= (a_neg_q ^ b_neg_q) ? -opa_q : opa_q;
                end else begin
                    res_q <= a_neg_q ? -acc_q : acc_q;  // remainder follows dividend sign
                end
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // handshake outputs
    ////////////////////////////////////////

    assign lane.req_ready = (state_q == muldiv_pkg::L_IDLE);
    assign lane.rsp_valid = (state_q == muldiv_pkg::L_DONE);

    always_comb begin
        if (op_q == muldiv_pkg::MUL) begin
            lane.rsp_data = prod_q[muldiv_pkg::XLEN-1:0];
        end else if (op_q inside {muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU}) begin
            lane.rsp_data = prod_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN];
        end else begin
            lane.rsp_data = res_q;
        end
    end

    a_rsp_data_held : assert property (
        @(posedge clk) disable iff (reset)
        lane.rsp_valid && !lane.rsp_ready |=> $stable(lane.rsp_data)
    ) else $error("lane result changed while waiting for the collector");

    a_no_ready_with_result : assert property (
        @(posedge clk) disable iff (reset)
        !(lane.req_ready && lane.rsp_valid)
    ) else $error("lane took a request while still holding a result");

endmodule

// File: muldiv_collect.sv
`timescale 1ns/1ps

module muldiv_collect (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rsp_valid_o,
    input  logic                         rsp_ready_i,
    output logic [muldiv_pkg::XLEN-1:0]  rsp_data_o,
    muldiv_lane_if.collect               lanes [muldiv_pkg::NUM_LANES]
);

    logic [muldiv_pkg::LANE_W-1:0]    drain_ptr;
    logic [muldiv_pkg::NUM_LANES-1:0] lane_valid;
    logic [muldiv_pkg::XLEN-1:0]      lane_data [muldiv_pkg::NUM_LANES];
    logic                             xfer;

    ////////////////////////////////////////
    // response gathering
    ////////////////////////////////////////

    for (genvar g = 0; g < muldiv_pkg::NUM_LANES; g++) begin : g_gather
        assign lane_valid[g] = lanes[g].rsp_valid;
        assign lane_data[g]  = lanes[g].rsp_data;
        // other lanes keep their results until their turn
        assign lanes[g].rsp_ready = rsp_ready_i && (int'(drain_ptr) == g);
    end

    // head lane only, so results leave in issue order
    assign rsp_valid_o = lane_valid[drain_ptr];
    assign rsp_data_o  = lane_data[drain_ptr];
    assign xfer        = rsp_valid_o && rsp_ready_i;

    ////////////////////////////////////////
    // drain pointer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_ptr <= '0;
        end else if (xfer) begin
            if (int'(drain_ptr) == muldiv_pkg::NUM_LANES - 1) begin
                drain_ptr <= '0;
            end else begin
                drain_ptr <= drain_ptr + 1'b1;
            end
        end
    end

    // keeps the drain order locked to the dispatcher's issue order
    a_drain_ptr_moves_on_xfer : assert property (
        @(posedge clk) disable iff (reset)
        !xfer |=> $stable(drain_ptr)
    ) else $error("drain pointer moved without a response transfer");

endmodule

// File: muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top (
    input  logic                         clk,
    input  logic                         reset,

    // request port
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  muldiv_pkg::muldiv_op_e       req_op_i,
    input  logic [muldiv_pkg::XLEN-1:0]  req_opa_i,
    input  logic [muldiv_pkg::XLEN-1:0]  req_opb_i,

    // response port, results in request order
    output logic                         rsp_valid_o,
    input  logic                         rsp_ready_i,
    output logic [muldiv_pkg::XLEN-1:0]  rsp_data_o
);

    muldiv_lane_if lane_if [muldiv_pkg::NUM_LANES] ();    // one bundle per lane

    muldiv_dispatch u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_opa_i   (req_opa_i),
        .req_opb_i   (req_opb_i),
        .lanes       (lane_if)
    );

    ////////////////////////////////////////
    // arithmetic lanes
    ////////////////////////////////////////

    for (genvar i = 0; i < muldiv_pkg::NUM_LANES; i++) begin : g_lane
        muldiv_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .lane  (lane_if[i])
        );
    end

    muldiv_collect u_collect (
        .clk         (clk),
        .reset       (reset),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o),
        .lanes       (lane_if)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;                       // released on the third edge
    end

endmodule

// File: tb_muldiv.sv
`timescale 1ns/1ps

module tb_muldiv;

    logic                         clk;
    logic                         reset;
    logic                         req_valid_i;
    logic                         req_ready_o;
    muldiv_pkg::muldiv_op_e       req_op_i;
    logic [muldiv_pkg::XLEN-1:0]  req_opa_i;
    logic [muldiv_pkg::XLEN-1:0]  req_opb_i;
    logic                         rsp_valid_o;
    logic                         rsp_ready_i;
    logic [muldiv_pkg::XLEN-1:0]  rsp_data_o;

    logic [muldiv_pkg::XLEN-1:0]  exp_q [$];     // expected results in issue order
    int                           id_q [$];
    logic [muldiv_pkg::XLEN-1:0]  exp_head = '0;
    logic                         exp_avail = 1'b0;
    int                           head_id = 0;
    int                           req_test = 0;
    int                           ready_mode = 0;   // 0 always, 1 random, 2 held low
    int                           err_cnt = 0;
    int                           req_cnt = 0;
    int                           rsp_cnt = 0;
    logic                         stall_seen = 1'b0;
    string test_names [4] = '{"arith", "corner", "order", "backpressure"};

    tb_clock u_clock (.clk(clk), .reset(reset));

    muldiv_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_opa_i   (req_opa_i),
        .req_opb_i   (req_opb_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] ref_result(input muldiv_pkg::muldiv_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            muldiv_pkg::MUL:    p = ua * ub;
            muldiv_pkg::MULH:   p = {32'b0, 32'(sa * sb >>> 32)};
            muldiv_pkg::MULHSU: p = {32'b0, 32'(sa * longint'(ub) >>> 32)};
            muldiv_pkg::MULHU:  p = {32'b0, 32'(ua * ub >> 32)};
            muldiv_pkg::DIV: begin
                if (b == '0) p = '1;
                else if (a == 32'h8000_0000 && b == '1) p = {32'b0, a};   // overflow
                else p = sa / sb;                                         // truncates to zero
            end
            muldiv_pkg::DIVU:   p = (b == '0) ? '1 : ua / ub;
            muldiv_pkg::REM: begin
                if (b == '0) p = {32'b0, a};
                else if (a == 32'h8000_0000 && b == '1) p = '0;
                else p = sa % sb;                                         // sign of dividend
            end
            default:            p = (b == '0) ? {32'b0, a} : ua % ub;
        endcase
        ref_result = p[31:0];
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 4)
            0:       rand_operand = r;
            1:       rand_operand = -(r % 100);            // small negative
            2:       rand_operand = r % 100;
            default: rand_operand = {1'b1, r[30:0]};       // large negative
        endcase
    endfunction

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    // called on a rising edge and returns on the edge that takes the request
    task automatic send(input muldiv_pkg::muldiv_op_e op, input logic [31:0] a,
                        input logic [31:0] b, input int id);
        int n;
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_opa_i   <= a;
        req_opb_i   <= b;
        req_test    <= id;
        n = 0;
        @(negedge clk);
        while (!req_ready_o && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready_o) begin
            err_cnt++;
            $display("request was not accepted within %0d cycles", n);
        end
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (exp_avail && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (exp_avail) begin
            err_cnt++;
            $display("results still outstanding after %0d cycles", n);
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            case (ready_mode)
                0:       rsp_ready_i <= 1'b1;
                1:       rsp_ready_i <= ($urandom % 3 != 0);   // random gaps
                default: rsp_ready_i <= 1'b0;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // monitor and checks
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            id_q.delete();
        end else begin
            if (rsp_valid_o && rsp_ready_i && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(id_q.pop_front());
                rsp_cnt <= rsp_cnt + 1;
            end
            if (req_valid_i && req_ready_o) begin
                exp_q.push_back(ref_result(req_op_i, req_opa_i, req_opb_i));
                id_q.push_back(req_test);
                req_cnt <= req_cnt + 1;
            end
            if (req_valid_i && !req_ready_o) stall_seen <= 1'b1;     // all lanes busy
        end
        exp_avail <= (exp_q.size() > 0);
        exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
        head_id   <= (id_q.size() > 0) ? id_q[0] : 0;
    end

    a_rsp_matches_model : assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid_o && rsp_ready_i && exp_avail |-> rsp_data_o == exp_head
    ) else begin
        err_cnt++;
        $display("Fail %s: expected %h, actual %h", test_names[$sampled(head_id)],
                 $sampled(exp_head), $sampled(rsp_data_o));
    end

    a_no_extra_rsp : assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid_o && rsp_ready_i |-> exp_avail
    ) else begin
        err_cnt++;
        $display("a response came out with no request outstanding");
    end

    a_rsp_held : assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o)
    ) else begin
        err_cnt++;
        $display("response was dropped or changed while rsp_ready_i was low");
    end

    a_reset_state : assert property (
        @(posedge clk) $fell(reset) |-> !rsp_valid_o && req_ready_o
    ) else begin
        err_cnt++;
        $display("outputs not in their reset state after reset");
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int n;
        muldiv_pkg::muldiv_op_e op;
        void'($urandom(87));
        req_valid_i = 1'b0;
        req_op_i    = muldiv_pkg::MUL;
        req_opa_i   = '0;
        req_opb_i   = '0;
        rsp_ready_i = 1'b0;
        fork
            drive_ready();
        join_none
        n = 0;
        @(posedge clk);
        while (reset && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset) begin
            err_cnt++;
            $display("reset never went low");
        end

        for (int i = 0; i < 48; i++) begin                      // all eight ops
            op = muldiv_pkg::muldiv_op_e'(3'($urandom % 8));
            send(op, rand_operand(), rand_operand(), 0);
        end
        req_valid_i <= 1'b0;
        wait_drain();
        @(posedge clk);

        send(muldiv_pkg::DIV,  $urandom, '0, 1);               // divide by zero
        send(muldiv_pkg::DIVU, $urandom, '0, 1);
        send(muldiv_pkg::REM,  $urandom, '0, 1);
        send(muldiv_pkg::REMU, $urandom, '0, 1);
        send(muldiv_pkg::DIV,  32'h8000_0000, '1, 1);          // signed overflow
        send(muldiv_pkg::REM,  32'h8000_0000, '1, 1);
        send(muldiv_pkg::DIVU, 32'h8000_0000, '1, 1);
        send(muldiv_pkg::REMU, 32'h8000_0000, '1, 1);

        send(muldiv_pkg::DIV,  $urandom, 32'd7, 2);            // slow op first
        send(muldiv_pkg::MUL,  rand_operand(), rand_operand(), 2);
        send(muldiv_pkg::MULH, rand_operand(), rand_operand(), 2);
        send(muldiv_pkg::MUL,  rand_operand(), rand_operand(), 2);
        req_valid_i <= 1'b0;
        wait_drain();
        @(posedge clk);

        ready_mode <= 2;
        for (int i = 0; i < 4; i++) begin                       // fill every lane
            send(muldiv_pkg::DIVU, $urandom, $urandom | 32'd1, 3);
        end
        fork
            send(muldiv_pkg::MUL, rand_operand(), rand_operand(), 3);
            begin
                repeat (50) @(posedge clk);
                ready_mode <= 1;
            end
        join
        for (int i = 0; i < 24; i++) begin
            op = muldiv_pkg::muldiv_op_e'(3'($urandom % 8));
            send(op, rand_operand(), rand_operand(), 3);
        end
        req_valid_i <= 1'b0;
        wait_drain();
        ready_mode <= 0;

        assert (stall_seen) else begin
            err_cnt++;
            $display("req_ready_o never fell while all lanes were full");
        end
        assert (req_cnt == rsp_cnt && !exp_avail) else begin
            err_cnt++;
            $display("request and response counts differ, a result was lost");
        end
        $display("errors: %0d, requests: %0d, responses: %0d", err_cnt, req_cnt, rsp_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: muldiv_top.f
muldiv_pkg.sv
muldiv_lane_if.sv
muldiv_dispatch.sv
muldiv_lane.sv
muldiv_collect.sv
muldiv_top.sv
tb_clock.sv
tb_muldiv.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the muldiv testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_muldiv \
    -f muldiv_top.f \
    -o tb_muldiv_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build step returned an error"
    exit 1
fi

./obj_dir/tb_muldiv_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
